/* Makefile */
# Verilator build and run of the SPI master testbench

VERILATOR ?= verilator
TOP       ?= spi_tb
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FAIL_MSG  := Something failed
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR=$(VERILATOR) TOP=$(TOP) LOG=$(LOG) BUILD_DIR=$(BUILD_DIR)"

test:
	$(VERILATOR) --binary --timing --assert -f compile.f --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
design/spi_pkg.sv
design/spi_sync_fifo.sv
design/spi_apb_regs.sv
design/spi_transfer_ctrl.sv
design/spi_master_shift.sv
design/spi_top.sv
sim/spi_tb.sv

/* design/spi_apb_regs.sv */
// APB slave with register file, sticky flags and reset release synchronizer
`timescale 1ns/1ps

module spi_apb_regs #(
	parameter int DATA_W     = 8,
	parameter int FIFO_DEPTH = 16
) (
	input  logic                           pclk,
	input  logic                           preset_n,
	// APB slave
	input  logic                           psel,
	input  logic                           penable,
	input  logic                           pwrite,
	input  logic [spi_pkg::APB_ADDR_W-1:0] paddr,
	input  logic [spi_pkg::APB_DATA_W-1:0] pwdata,
	input  logic [spi_pkg::APB_STRB_W-1:0] pstrb,
	output logic [spi_pkg::APB_DATA_W-1:0] prdata,
	output logic                           pready,
	output logic                           pslverr,
	output logic                           rst_n_sync,
	// FIFO status
	input  logic [$clog2(FIFO_DEPTH):0]    tx_count,
	input  logic                           tx_empty,
	input  logic                           tx_full,
	input  logic [$clog2(FIFO_DEPTH):0]    rx_count,
	input  logic                           rx_empty,
	input  logic                           rx_full,
	input  logic [DATA_W-1:0]              rx_rdata,
	input  logic                           busy,
	input  logic                           rx_overflow_evt,
	// FIFO control
	output logic                           tx_push,
	output logic [DATA_W-1:0]              tx_wdata,
	output logic                           rx_pop,
	output logic                           soft_clear,
	// Transfer settings
	output logic                           spi_en,
	output logic                           cpol,
	output logic                           cpha,
	output logic [spi_pkg::BAUD_W-1:0]     baud,
	output logic [spi_pkg::SS_W-1:0]       ss_sel
);

	import spi_pkg::*;

	localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

	logic                  rst_meta;
	logic                  setup_ph;
	logic                  access_ph;
	logic                  addr_err;
	logic                  wr_en;
	logic                  ctrl_wr;
	logic                  baud_wr;
	logic                  tx_overflow;
	logic                  rx_overflow;
	logic                  rx_underflow;
	logic [APB_DATA_W-1:0] status_val;
	logic [APB_DATA_W-1:0] flags_val;
	logic [APB_DATA_W-1:0] rd_val;

	// ======================================================================
	// Reset release, two flops deep
	// ======================================================================
	always_ff @(posedge pclk or negedge preset_n)
	begin
		if (!preset_n)
		begin
			rst_meta   <= 1'b0;
			rst_n_sync <= 1'b0;
		end
		else
		begin
			rst_meta   <= 1'b1;
			rst_n_sync <= rst_meta;
		end
	end

	// ======================================================================
	// APB decode
	// ======================================================================
	assign setup_ph  = psel && !penable;
	assign access_ph = psel && penable;

	// Misaligned, partial strobe, out of range, or write to a read-only register
	assign addr_err = (|paddr[1:0]) || !(&pstrb) || (paddr > ADDR_RXDATA) ||
		(pwrite && ((paddr == ADDR_STATUS) || (paddr == ADDR_FLAGS) ||
		(paddr == ADDR_RXDATA)));

	assign wr_en   = access_ph && pwrite && !addr_err;
	assign ctrl_wr = wr_en && (paddr == ADDR_CTRL);
	assign baud_wr = wr_en && (paddr == ADDR_BAUD);

	assign tx_push    = wr_en && (paddr == ADDR_TXDATA);
	assign tx_wdata   = pwdata[DATA_W-1:0];
	assign soft_clear = ctrl_wr && pwdata[CTRL_CLR_BIT];
	assign rx_pop     = access_ph && !pwrite && !addr_err && (paddr == ADDR_RXDATA);
	assign pready     = 1'b1;

	// Control and baud registers, clear bit is self-clearing
	always_ff @(posedge pclk or negedge rst_n_sync)
	begin
		if (!rst_n_sync)
		begin
			spi_en <= 1'b0;
			cpol   <= 1'b0;
			cpha   <= 1'b0;
			ss_sel <= '0;
			baud   <= '0;
		end
		else
		begin
			if (ctrl_wr)
			begin
				spi_en <= pwdata[CTRL_EN_BIT];
				cpol   <= pwdata[CTRL_CPOL_BIT];
				cpha   <= pwdata[CTRL_CPHA_BIT];
				ss_sel <= pwdata[CTRL_SS_LSB +: SS_W];
			end
			if (baud_wr)
				baud <= pwdata[BAUD_W-1:0];
		end
	end

	// Sticky error flags
	always_ff @(posedge pclk or negedge rst_n_sync)
	begin
		if (!rst_n_sync)
		begin
			tx_overflow  <= 1'b0;
			rx_overflow  <= 1'b0;
			rx_underflow <= 1'b0;
		end
		else if (soft_clear)
		begin
			tx_overflow  <= 1'b0;
			rx_overflow  <= 1'b0;
			rx_underflow <= 1'b0;
		end
		else
		begin
			if (tx_push && tx_full)
				tx_overflow <= 1'b1;
			if (rx_overflow_evt)
				rx_overflow <= 1'b1;
			if (rx_pop && rx_empty)
				rx_underflow <= 1'b1;
		end
	end

	// ======================================================================
	// Read path
	// ======================================================================
	always_comb
	begin
		status_val = '0;
		status_val[ST_TXCNT_LSB +: CNT_W] = tx_count;
		status_val[ST_RXCNT_LSB +: CNT_W] = rx_count;
		status_val[ST_TX_EMPTY_BIT] = tx_empty;
		status_val[ST_TX_FULL_BIT]  = tx_full;
		status_val[ST_RX_EMPTY_BIT] = rx_empty;
		status_val[ST_RX_FULL_BIT]  = rx_full;
		status_val[ST_BUSY_BIT]     = busy;

		flags_val = '0;
		flags_val[FL_TX_OVF_BIT] = tx_overflow;
		flags_val[FL_RX_OVF_BIT] = rx_overflow;
		flags_val[FL_RX_UNF_BIT] = rx_underflow;

		rd_val = '0;
		case (paddr)
			ADDR_CTRL:
			begin
				rd_val[CTRL_EN_BIT]         = spi_en;
				rd_val[CTRL_CPOL_BIT]       = cpol;
				rd_val[CTRL_CPHA_BIT]       = cpha;
				rd_val[CTRL_SS_LSB +: SS_W] = ss_sel;
			end
			ADDR_BAUD:
				rd_val[BAUD_W-1:0] = baud;
			ADDR_STATUS:
				rd_val = status_val;
			ADDR_FLAGS:
				rd_val = flags_val;
			ADDR_RXDATA:
			begin
				// Empty FIFO reads as zero
				if (!rx_empty)
					rd_val[DATA_W-1:0] = rx_rdata;
			end
			default:
				rd_val = '0;
		endcase
	end

	// Response captured in setup so it is stable through the access phase
	always_ff @(posedge pclk or negedge rst_n_sync)
	begin
		if (!rst_n_sync)
		begin
			prdata  <= '0;
			pslverr <= 1'b0;
		end
		else
		begin
			pslverr <= setup_ph && addr_err;
			if (setup_ph)
				prdata <= (!pwrite && !addr_err) ? rd_val : '0;
		end
	end

endmodule

/* design/spi_master_shift.sv */
// SPI master shifter with baud divider, SCLK generation and slave select drive
`timescale 1ns/1ps

module spi_master_shift #(
	parameter int DATA_W = 8,
	parameter int BAUD_W = spi_pkg::BAUD_W
) (
	input  logic                       pclk,
	input  logic                       rst_n,
	input  logic                       frame_start,
	input  logic [DATA_W-1:0]          frame_data,
	input  logic                       cpol,
	input  logic                       cpha,
	input  logic [BAUD_W-1:0]          baud,
	input  logic [spi_pkg::SS_W-1:0]   ss_sel,
	input  logic                       miso,
	output logic                       frame_done,
	output logic [DATA_W-1:0]          frame_rdata,
	output logic                       sclk,
	output logic                       mosi,
	output logic [spi_pkg::NUM_SS-1:0] ss_n
);

	import spi_pkg::*;

	localparam int EDGE_W = $clog2(2 * DATA_W + 1);
	localparam logic [EDGE_W-1:0] LAST_EDGE = EDGE_W'(2 * DATA_W);

	logic              active;
	logic              load;
	logic [BAUD_W-1:0] div_cnt;
	logic [EDGE_W-1:0] edge_cnt;
	logic              half_tick;
	logic              edge_tick;
	logic              end_tick;
	logic              launch;
	logic              sample;
	logic [NUM_SS-1:0] sel_dec;
	logic [DATA_W-1:0] tx_sh;
	logic [DATA_W-1:0] rx_sh;

	// ======================================================================
	// Baud divider and edge counter
	// ======================================================================
	assign load      = frame_start && !active;
	assign half_tick = active && (div_cnt == baud);
	assign edge_tick = half_tick && (edge_cnt != LAST_EDGE);

	// One extra half period after the last edge before deselect
	assign end_tick = half_tick && (edge_cnt == LAST_EDGE);

	// Even edges lead, odd edges trail
	assign launch = edge_tick && (edge_cnt[0] != cpha);
	assign sample = edge_tick && (edge_cnt[0] == cpha);

	always_ff @(posedge pclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			active   <= 1'b0;
			div_cnt  <= '0;
			edge_cnt <= '0;
		end
		else if (load)
		begin
			active   <= 1'b1;
			div_cnt  <= '0;
			edge_cnt <= '0;
		end
		else if (active)
		begin
			if (half_tick)
			begin
				div_cnt  <= '0;
				edge_cnt <= edge_cnt + 1'b1;
			end
			else
				div_cnt <= div_cnt + 1'b1;
			if (end_tick)
				active <= 1'b0;
		end
	end

	// Active-low select for the requested slave
	always_comb
	begin
		sel_dec = '1;
		sel_dec[ss_sel] = 1'b0;
	end

	// ======================================================================
	// SPI pins
	// ======================================================================
	always_ff @(posedge pclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sclk       <= 1'b0;
			mosi       <= 1'b0;
			ss_n       <= '1;
			frame_done <= 1'b0;
		end
		else
		begin
			frame_done <= end_tick;

			if (!active)
				sclk <= cpol;
			else if (edge_tick)
				sclk <= ~sclk;

			// With cpha=0 the MSB must be on the line before the first edge
			if (load)
			begin
				ss_n <= sel_dec;
				mosi <= cpha ? 1'b0 : frame_data[DATA_W-1];
			end
			else if (end_tick)
			begin
				ss_n <= '1;
				mosi <= 1'b0;
			end
			else if (launch)
				mosi <= tx_sh[DATA_W-1];
		end
	end

	// Shift registers, MSB first
	always_ff @(posedge pclk)
	begin
		if (load)
			tx_sh <= cpha ? frame_data : {frame_data[DATA_W-2:0], 1'b0};
		else if (launch)
			tx_sh <= {tx_sh[DATA_W-2:0], 1'b0};

		if (sample)
			rx_sh <= {rx_sh[DATA_W-2:0], miso};
	end

	assign frame_rdata = rx_sh;

	assert property (@(posedge pclk) disable iff (!rst_n)
		$onehot0(~ss_n))
	else
		$error("more than one slave select low");

endmodule

/* design/spi_pkg.sv */
// SPI master shared bus widths, register map and register bit positions
package spi_pkg;

	// ======================================================================
	// APB bus
	// ======================================================================
	localparam int APB_ADDR_W = 5;
	localparam int APB_DATA_W = 32;
	localparam int APB_STRB_W = APB_DATA_W / 8;

	// Register byte offsets
	localparam logic [APB_ADDR_W-1:0] ADDR_CTRL   = 5'h00;
	localparam logic [APB_ADDR_W-1:0] ADDR_BAUD   = 5'h04;
	localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 5'h08;
	localparam logic [APB_ADDR_W-1:0] ADDR_FLAGS  = 5'h0C;
	localparam logic [APB_ADDR_W-1:0] ADDR_TXDATA = 5'h10;
	localparam logic [APB_ADDR_W-1:0] ADDR_RXDATA = 5'h14;

	// ======================================================================
	// CTRL and BAUD fields
	// ======================================================================
	localparam int CTRL_EN_BIT   = 0;
	localparam int CTRL_CPOL_BIT = 1;
	localparam int CTRL_CPHA_BIT = 2;
	localparam int CTRL_CLR_BIT  = 3;
	localparam int CTRL_SS_LSB   = 4;

	localparam int NUM_SS = 4;
	localparam int SS_W   = $clog2(NUM_SS);
	localparam int BAUD_W = 8;

	// STATUS layout
	localparam int ST_TXCNT_LSB    = 0;
	localparam int ST_RXCNT_LSB    = 8;
	localparam int ST_TX_EMPTY_BIT = 16;
	localparam int ST_TX_FULL_BIT  = 17;
	localparam int ST_RX_EMPTY_BIT = 18;
	localparam int ST_RX_FULL_BIT  = 19;
	localparam int ST_BUSY_BIT     = 20;

	// Sticky FLAGS layout
	localparam int FL_TX_OVF_BIT = 0;
	localparam int FL_RX_OVF_BIT = 1;
	localparam int FL_RX_UNF_BIT = 2;

endpackage

/* design/spi_sync_fifo.sv */
// Synchronous FIFO with wrap-bit pointers, fill count and full/empty flags
`timescale 1ns/1ps

module spi_sync_fifo #(
	parameter int DATA_W     = 8,
	parameter int FIFO_DEPTH = 16
) (
	input  logic                        pclk,
	input  logic                        rst_n,
	input  logic                        clear,
	input  logic                        push,
	input  logic [DATA_W-1:0]           wdata,
	input  logic                        pop,
	output logic [DATA_W-1:0]           rdata,
	output logic [$clog2(FIFO_DEPTH):0] count,
	output logic                        empty,
	output logic                        full
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	// Extra MSB on each pointer tells a full FIFO from an empty one
	logic [PTR_W:0]    wr_ptr;
	logic [PTR_W:0]    rd_ptr;
	logic              wr_en;
	logic              rd_en;
	logic [DATA_W-1:0] mem [FIFO_DEPTH];

	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	always_ff @(posedge pclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else if (clear)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge pclk)
	begin
		if (wr_en)
			mem[wr_ptr[PTR_W-1:0]] <= wdata;
	end

	// Head word straight from the read pointer
	assign rdata = mem[rd_ptr[PTR_W-1:0]];

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
		(wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
	assign count = wr_ptr - rd_ptr;

	// A rejected push must leave the stored words untouched
	assert property (@(posedge pclk) disable iff (!rst_n)
		(push && full && !clear) |=> (wr_ptr == $past(wr_ptr)))
	else
		$error("FIFO write pointer moved on a push while full");

endmodule

/* design/spi_top.sv */
// SPI master top level joining the APB registers, FIFOs, sequencer and shifter
`timescale 1ns/1ps

module spi_top #(
	parameter int DATA_W     = 8,
	parameter int FIFO_DEPTH = 16
) (
	input  logic                           pclk,
	input  logic                           preset_n,
	// APB slave
	input  logic                           psel,
	input  logic                           penable,
	input  logic                           pwrite,
	input  logic [spi_pkg::APB_ADDR_W-1:0] paddr,
	input  logic [spi_pkg::APB_DATA_W-1:0] pwdata,
	input  logic [spi_pkg::APB_STRB_W-1:0] pstrb,
	output logic [spi_pkg::APB_DATA_W-1:0] prdata,
	output logic                           pready,
	output logic                           pslverr,
	// SPI master pins
	output logic                           sclk,
	output logic                           mosi,
	input  logic                           miso,
	output logic [spi_pkg::NUM_SS-1:0]     ss_n
);

	import spi_pkg::*;

	localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

	logic              rst_n_sync;
	logic              soft_clear;
	// TX FIFO
	logic              tx_push;
	logic              tx_pop;
	logic [DATA_W-1:0] tx_wdata;
	logic [DATA_W-1:0] tx_rdata;
	logic [CNT_W-1:0]  tx_count;
	logic              tx_empty;
	logic              tx_full;
	// RX FIFO
	logic              rx_push;
	logic              rx_pop;
	logic [DATA_W-1:0] rx_wdata;
	logic [DATA_W-1:0] rx_rdata;
	logic [CNT_W-1:0]  rx_count;
	logic              rx_empty;
	logic              rx_full;
	logic              rx_overflow_evt;
	// Settings and frame control
	logic              spi_en;
	logic              cpol;
	logic              cpha;
	logic [BAUD_W-1:0] baud;
	logic [SS_W-1:0]   ss_sel;
	logic              busy;
	logic              frame_start;
	logic              frame_done;
	logic [DATA_W-1:0] frame_data;
	logic [DATA_W-1:0] frame_rdata;

	spi_apb_regs #(
		.DATA_W(DATA_W),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_regs (
		.pclk(pclk),
		.preset_n(preset_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pstrb(pstrb),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.rst_n_sync(rst_n_sync),
		.tx_count(tx_count),
		.tx_empty(tx_empty),
		.tx_full(tx_full),
		.rx_count(rx_count),
		.rx_empty(rx_empty),
		.rx_full(rx_full),
		.rx_rdata(rx_rdata),
		.busy(busy),
		.rx_overflow_evt(rx_overflow_evt),
		.tx_push(tx_push),
		.tx_wdata(tx_wdata),
		.rx_pop(rx_pop),
		.soft_clear(soft_clear),
		.spi_en(spi_en),
		.cpol(cpol),
		.cpha(cpha),
		.baud(baud),
		.ss_sel(ss_sel)
	);

	spi_sync_fifo #(
		.DATA_W(DATA_W),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_tx_fifo (
		.pclk(pclk),
		.rst_n(rst_n_sync),
		.clear(soft_clear),
		.push(tx_push),
		.wdata(tx_wdata),
		.pop(tx_pop),
		.rdata(tx_rdata),
		.count(tx_count),
		.empty(tx_empty),
		.full(tx_full)
	);

	spi_sync_fifo #(
		.DATA_W(DATA_W),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_rx_fifo (
		.pclk(pclk),
		.rst_n(rst_n_sync),
		.clear(soft_clear),
		.push(rx_push),
		.wdata(rx_wdata),
		.pop(rx_pop),
		.rdata(rx_rdata),
		.count(rx_count),
		.empty(rx_empty),
		.full(rx_full)
	);

	spi_transfer_ctrl #(
		.DATA_W(DATA_W)
	) u_ctrl (
		.pclk(pclk),
		.rst_n(rst_n_sync),
		.spi_en(spi_en),
		.tx_empty(tx_empty),
		.tx_rdata(tx_rdata),
		.frame_done(frame_done),
		.frame_rdata(frame_rdata),
		.rx_full(rx_full),
		.tx_pop(tx_pop),
		.frame_start(frame_start),
		.frame_data(frame_data),
		.rx_push(rx_push),
		.rx_wdata(rx_wdata),
		.busy(busy),
		.rx_overflow_evt(rx_overflow_evt)
	);

	spi_master_shift #(
		.DATA_W(DATA_W),
		.BAUD_W(BAUD_W)
	) u_shift (
		.pclk(pclk),
		.rst_n(rst_n_sync),
		.frame_start(frame_start),
		.frame_data(frame_data),
		.cpol(cpol),
		.cpha(cpha),
		.baud(baud),
		.ss_sel(ss_sel),
		.miso(miso),
		.frame_done(frame_done),
		.frame_rdata(frame_rdata),
		.sclk(sclk),
		.mosi(mosi),
		.ss_n(ss_n)
	);

endmodule

/* design/spi_transfer_ctrl.sv */
// Transfer sequencer moving words from the TX FIFO through the shifter to the RX FIFO
`timescale 1ns/1ps

module spi_transfer_ctrl #(
	parameter int DATA_W = 8
) (
	input  logic              pclk,
	input  logic              rst_n,
	input  logic              spi_en,
	input  logic              tx_empty,
	input  logic [DATA_W-1:0] tx_rdata,
	input  logic              frame_done,
	input  logic [DATA_W-1:0] frame_rdata,
	input  logic              rx_full,
	output logic              tx_pop,
	output logic              frame_start,
	output logic [DATA_W-1:0] frame_data,
	output logic              rx_push,
	output logic [DATA_W-1:0] rx_wdata,
	output logic              busy,
	output logic              rx_overflow_evt
);

	typedef enum logic {
		IDLE,
		BUSY
	} state_t;

	state_t state;
	logic   start_ok;

	// ======================================================================
	// Frame launch
	// ======================================================================
	assign start_ok    = (state == IDLE) && spi_en && !tx_empty;
	assign tx_pop      = start_ok;
	assign frame_start = start_ok;

	// Shifter loads the head word in the start cycle
	assign frame_data = tx_rdata;

	always_ff @(posedge pclk or negedge rst_n)
	begin
		if (!rst_n)
			state <= IDLE;
		else
		begin
			case (state)
				IDLE:
				begin
					if (start_ok)
						state <= BUSY;
				end
				BUSY:
				begin
					if (frame_done)
						state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// ======================================================================
	// Result hand-off
	// ======================================================================
	always_ff @(posedge pclk or negedge rst_n)
	begin
		if (!rst_n)
			rx_push <= 1'b0;
		else
			rx_push <= frame_done;
	end

	always_ff @(posedge pclk)
	begin
		if (frame_done)
			rx_wdata <= frame_rdata;
	end

	// Result still in flight counts as busy
	assign busy = (state == BUSY) || rx_push;

	// Word is lost when the RX FIFO refuses it
	assign rx_overflow_evt = rx_push && rx_full;

	assert property (@(posedge pclk) disable iff (!rst_n)
		frame_start |-> (state == IDLE))
	else
		$error("frame_start issued outside IDLE");

	// Shifter only completes frames that were started here
	assert property (@(posedge pclk) disable iff (!rst_n)
		frame_done |-> (state == BUSY))
	else
		$error("frame_done seen with no frame in progress");

endmodule

/* sim/spi_tb.sv */
// Testbench for the APB SPI master, run from a command file against an SPI slave model
`timescale 1ns/1ps

module spi_tb;

	import spi_pkg::*;

	localparam int DATA_W     = 8;
	localparam int FIFO_DEPTH = 16;
	localparam int MAX_CMDS   = 128;
	localparam int SEED       = 48991;

	logic                  pclk = 1'b0;
	logic                  preset_n;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [APB_ADDR_W-1:0] paddr;
	logic [APB_DATA_W-1:0] pwdata;
	logic [APB_STRB_W-1:0] pstrb;
	logic [APB_DATA_W-1:0] prdata;
	logic                  pready;
	logic                  pslverr;
	logic                  sclk;
	logic                  mosi;
	logic                  miso;
	logic [NUM_SS-1:0]     ss_n;
	logic                  ss_low;

	// Command table loaded from the data file
	logic [7:0]            cmd_op [MAX_CMDS];
	logic [31:0]           cmd_a [MAX_CMDS];
	logic [31:0]           cmd_b [MAX_CMDS];
	logic [31:0]           cmd_c [MAX_CMDS];
	logic [127:0]          cmd_name [MAX_CMDS];
	int                    n_cmds;

	// Expected state kept by the testbench
	logic                  cur_en;
	logic                  cur_cpol;
	logic                  cur_cpha;
	logic [SS_W-1:0]       cur_ss;
	logic [DATA_W-1:0]     tx_exp [$];
	logic [DATA_W-1:0]     reply_q [$];

	// Slave model state
	logic [DATA_W-1:0]     slave_tx;
	logic [DATA_W-1:0]     slave_rx;
	logic [DATA_W-1:0]     exp_word;
	logic                  exp_valid;
	logic                  ss_low_d;
	int                    bit_cnt;

	logic                  reset_done;
	int                    error_cnt;
	int                    test_err_start;
	int                    tests_passed;
	int                    tests_failed;
	int                    cycle_cnt;
	int                    cycle_limit;

	spi_top #(
		.DATA_W(DATA_W),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_spi_top (
		.pclk(pclk),
		.preset_n(preset_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pstrb(pstrb),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.sclk(sclk),
		.mosi(mosi),
		.miso(miso),
		.ss_n(ss_n)
	);

	always #5 pclk = ~pclk;

	always @(posedge pclk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if ((cycle_limit != 0) && (cycle_cnt >= cycle_limit))
		begin
			$display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
			$display("Something failed");
			$finish;
		end
	end

	task automatic flag_mismatch(input string msg);
		error_cnt++;
		$display("CHECK FAILED time %0t: %s", $time, msg);
	endtask

	task automatic flag_problem(input string msg);
		error_cnt++;
		$display("ERROR time %0t: %s", $time, msg);
	endtask

	// ======================================================================
	// APB master
	// ======================================================================
	task automatic apb_access(input logic wr, input logic [APB_ADDR_W-1:0] addr,
		input logic [31:0] wdata, input logic [3:0] strb,
		output logic [31:0] rdata, output logic err);
		int gap;
		// Random idle gap ahead of the setup phase
		gap = $urandom % 3;
		repeat (gap) @(posedge pclk);
		@(posedge pclk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		pstrb   = strb;
		@(posedge pclk);
		#1;
		penable = 1'b1;
		// Response is stable through the access phase
		@(negedge pclk);
		rdata = prdata;
		err   = pslverr;
		if (pready !== 1'b1)
			flag_mismatch("pready low in the access phase");
		@(posedge pclk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	// Mirror an accepted write into the expected state
	task automatic update_model(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
		if (addr == ADDR_CTRL)
		begin
			cur_en   = data[CTRL_EN_BIT];
			cur_cpol = data[CTRL_CPOL_BIT];
			cur_cpha = data[CTRL_CPHA_BIT];
			cur_ss   = data[CTRL_SS_LSB +: SS_W];
			if (data[CTRL_CLR_BIT])
				tx_exp.delete();
		end
		else if ((addr == ADDR_TXDATA) && (tx_exp.size() < FIFO_DEPTH))
			tx_exp.push_back(data[DATA_W-1:0]);
	endtask

	task automatic do_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic        err;
		apb_access(1'b1, addr, data, 4'hF, rd, err);
		if (err)
			flag_mismatch($sformatf("pslverr on write of %h to %h", data, addr));
		else
			update_model(addr, data);
	endtask

	task automatic do_read(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] exp);
		logic [31:0] rd;
		logic        err;
		apb_access(1'b0, addr, 32'h0, 4'hF, rd, err);
		if (err)
			flag_mismatch($sformatf("pslverr on read of %h", addr));
		else if (rd !== exp)
			flag_mismatch($sformatf("read %h returned %h, expected %h", addr, rd, exp));
	endtask

	task automatic expect_error(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		logic [31:0] rd;
		logic        err;
		apb_access(1'b1, addr, data, strb, rd, err);
		if (!err)
			flag_mismatch($sformatf("no pslverr on write to %h with strobe %h", addr, strb));
	endtask

	// Poll STATUS until the TX side is empty and the last result is stored
	task automatic wait_drained;
		logic [31:0] st;
		logic        err;
		logic        done;
		done = 1'b0;
		while (!done)
		begin
			apb_access(1'b0, ADDR_STATUS, 32'h0, 4'hF, st, err);
			done = !st[ST_BUSY_BIT] && st[ST_TX_EMPTY_BIT] && (&ss_n);
		end
	endtask

	task automatic finish_test(input logic [127:0] name);
		if (error_cnt == test_err_start)
		begin
			tests_passed++;
			$display("Test %0s: passed", name);
		end
		else
		begin
			tests_failed++;
			$display("Test %0s: FAILED with %0d errors", name, error_cnt - test_err_start);
		end
		test_err_start = error_cnt;
	endtask

	// ======================================================================
	// SPI slave model
	// ======================================================================
	task automatic slave_frame_begin;
		logic [NUM_SS-1:0] sel_exp;
		sel_exp = ~(NUM_SS'(1) << cur_ss);
		if (!cur_en)
			flag_problem("a slave select went low while the master was disabled");
		if (ss_n !== sel_exp)
			flag_mismatch($sformatf("ss_n is %b, expected %b", ss_n, sel_exp));
		if (sclk !== cur_cpol)
			flag_mismatch("sclk not at its idle level when the frame starts");
		slave_tx = (reply_q.size() > 0) ? reply_q.pop_front() : '0;
		exp_valid = (tx_exp.size() > 0);
		if (exp_valid)
			exp_word = tx_exp.pop_front();
		else
			flag_problem("a frame started with no TXDATA word outstanding");
		slave_rx = '0;
		bit_cnt  = 0;
		// cpha=0 needs the first bit before the first edge
		if (!cur_cpha)
		begin
			miso     = slave_tx[DATA_W-1];
			slave_tx = {slave_tx[DATA_W-2:0], 1'b0};
		end
	endtask

	task automatic slave_clock_edge;
		logic leading;
		leading = (sclk != cur_cpol);
		if (leading == !cur_cpha)
		begin
			slave_rx = {slave_rx[DATA_W-2:0], mosi};
			bit_cnt++;
		end
		else
		begin
			miso     = slave_tx[DATA_W-1];
			slave_tx = {slave_tx[DATA_W-2:0], 1'b0};
		end
	endtask

	task automatic slave_frame_end;
		if (bit_cnt != DATA_W)
			flag_mismatch($sformatf("frame had %0d sampling edges, expected %0d", bit_cnt, DATA_W));
		if (exp_valid && (slave_rx !== exp_word))
			flag_mismatch($sformatf("mosi word %h, expected %h", slave_rx, exp_word));
		if (sclk !== cur_cpol)
			flag_mismatch("sclk not back at its idle level when the frame ends");
	endtask

	assign ss_low = ~(&ss_n);

	always @(posedge ss_low or negedge ss_low or posedge sclk or negedge sclk)
	begin
		if (reset_done)
		begin
			if (ss_low && !ss_low_d)
				slave_frame_begin();
			else if (!ss_low && ss_low_d)
				slave_frame_end();
			else if (ss_low)
				slave_clock_edge();
		end
		ss_low_d = ss_low;
	end

	// ======================================================================
	// Main sequence
	// ======================================================================
	initial
	begin : main
		int            fd;
		int            r;
		logic [7:0]    op;
		logic [31:0]   rd_a;
		logic [31:0]   rd_b;
		logic [31:0]   rd_c;
		logic [127:0]  nm;
		logic [1023:0] line_buf;

		preset_n = 1'b0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		pstrb    = '0;
		miso     = 1'b0;
		cur_en   = 1'b0;
		cur_cpol = 1'b0;
		cur_cpha = 1'b0;
		cur_ss   = '0;
		ss_low_d = 1'b0;
		exp_valid  = 1'b0;
		reset_done = 1'b0;
		error_cnt  = 0;
		test_err_start = 0;
		tests_passed   = 0;
		tests_failed   = 0;
		cycle_cnt   = 0;
		cycle_limit = 0;
		n_cmds      = 0;
		void'($urandom(SEED));

		fd = $fopen("sim/spi_testdata.txt", "r");
		if (fd == 0)
			flag_problem("cannot open sim/spi_testdata.txt");
		else
		begin
			while ($fscanf(fd, "%s", op) == 1)
			begin
				rd_a = '0;
				rd_b = '0;
				rd_c = '0;
				nm   = '0;
				if (op == "#")
					r = $fgets(line_buf, fd);
				else
				begin
					case (op)
						"W", "R":
							r = $fscanf(fd, "%h %h", rd_a, rd_b);
						"E":
							r = $fscanf(fd, "%h %h %h", rd_a, rd_b, rd_c);
						"S":
							r = $fscanf(fd, "%h", rd_a);
						"T":
							r = $fscanf(fd, "%s", nm);
						default:
							r = 0;
					endcase
					if (n_cmds < MAX_CMDS)
					begin
						cmd_op[n_cmds]   = op;
						cmd_a[n_cmds]    = rd_a;
						cmd_b[n_cmds]    = rd_b;
						cmd_c[n_cmds]    = rd_c;
						cmd_name[n_cmds] = nm;
						n_cmds++;
					end
					else
						flag_problem("too many commands in the data file");
				end
			end
			$fclose(fd);
		end

		// Worst case per command is one full frame at the slowest baud
		cycle_limit = (n_cmds + 8) * (2 * DATA_W * 256 + 40);

		repeat (4) @(posedge pclk);
		#1;
		preset_n = 1'b1;
		repeat (3) @(posedge pclk);
		reset_done = 1'b1;
		if ((ss_n !== '1) || (mosi !== 1'b0) || (sclk !== 1'b0) || (pslverr !== 1'b0))
			flag_mismatch("SPI pins or pslverr not at their reset values");

		for (int i = 0; i < n_cmds; i++)
		begin
			case (cmd_op[i])
				"W":
					do_write(cmd_a[i][APB_ADDR_W-1:0], cmd_b[i]);
				"R":
					do_read(cmd_a[i][APB_ADDR_W-1:0], cmd_b[i]);
				"E":
					expect_error(cmd_a[i][APB_ADDR_W-1:0], cmd_b[i], cmd_c[i][3:0]);
				"S":
					reply_q.push_back(cmd_a[i][DATA_W-1:0]);
				"D":
					wait_drained();
				"T":
					finish_test(cmd_name[i]);
				default:
					flag_problem($sformatf("unknown command at entry %0d", i));
			endcase
		end

		if (reply_q.size() != 0)
			flag_problem("slave replies left unused at the end of the run");
		if (tx_exp.size() != 0)
			flag_problem("TXDATA words never seen on mosi");

		$display("Tests passed: %0d, tests failed: %0d, errors: %0d",
			tests_passed, tests_failed, error_cnt);
		if ((error_cnt == 0) && (tests_failed == 0) && (tests_passed > 0))
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* sim/spi_testdata.txt */
# op addr data [strb]: W write, R read and compare, E write that must give pslverr
# S reply word for the slave model, D wait until the TX side drains, T name ends a test
R 08 00050000
W 04 000000A5
R 04 000000A5
W 00 00000020
R 00 00000020
E 02 00000001 F
E 00 00000001 1
E 08 00000000 F
R 00 00000020
R 04 000000A5
R 08 00050000
T registers
W 04 00000001
W 00 00000001
S 3C
W 10 000000A6
D
R 08 00010100
R 14 0000003C
R 08 00050000
T mode0
W 04 00000002
W 00 00000015
S C3
W 10 0000005A
D
R 14 000000C3
T mode1
W 00 00000023
S 81
W 10 000000E7
D
R 14 00000081
T mode2
W 00 00000037
S 6D
W 10 00000019
D
R 14 0000006D
T mode3
W 00 00000000
S 11
S 22
S 33
W 10 000000F0
W 10 0000000F
W 10 00000055
R 08 00040003
W 00 00000001
D
R 08 00010300
R 14 00000011
R 14 00000022
R 14 00000033
R 08 00050000
T queue
W 00 00000000
W 10 00000040
W 10 00000041
W 10 00000042
W 10 00000043
W 10 00000044
W 10 00000045
W 10 00000046
W 10 00000047
W 10 00000048
W 10 00000049
W 10 0000004A
W 10 0000004B
W 10 0000004C
W 10 0000004D
W 10 0000004E
W 10 0000004F
W 10 00000050
R 08 00060010
R 0C 00000001
R 14 00000000
R 0C 00000005
W 00 00000008
R 0C 00000000
R 08 00050000
R 00 00000000
T overflow
